// File: Bender.yml
package:
  name: rv_pipeline

sources:
  - design/rv_isa_pkg.sv
  - design/rv_pipe_pkg.sv
  - design/rv_alu.sv
  - design/rv_decoder.sv
  - design/rv_regfile.sv
  - design/rv_hazard_unit.sv
  - design/rv_pipeline.sv
  - target: test
    files:
      - testbench/tb_rv_pipeline.sv

// File: design/rv_alu.sv
module rv_alu (
    input  rv_isa_pkg::alu_op_e op,
    input  rv_isa_pkg::word_t   a,
    input  rv_isa_pkg::word_t   b,
    output rv_isa_pkg::word_t   result
);
    import rv_isa_pkg::*;

    logic [SHAMT_W-1:0] shamt;

    // Only the low bits of b count for shifts
    assign shamt = b[SHAMT_W-1:0];

    always_comb begin
        case (op)
            ALU_ADD: result = a + b;
            ALU_SUB: result = a - b;
            ALU_SLL: result = a << shamt;
            ALU_SRL: result = a >> shamt;
            ALU_SRA: result = $signed(a) >>> shamt;
            ALU_XOR: result = a ^ b;
            ALU_OR:  result = a | b;
            ALU_AND: result = a & b;
            // Signed compare giving one or zero
            ALU_SLT: result = word_t'($signed(a) < $signed(b));
            default: result = '0;
        endcase
    end

endmodule

// File: design/rv_decoder.sv
module rv_decoder (
    input  rv_pipe_pkg::if_id_t    inst,
    output rv_pipe_pkg::ctrl_t     ctrl,
    output rv_isa_pkg::reg_addr_t  rs1_addr,
    output rv_isa_pkg::reg_addr_t  rs2_addr,
    output rv_isa_pkg::reg_addr_t  rd_addr,
    output rv_isa_pkg::word_t      imm
);
    import rv_isa_pkg::*;

    opcode_t    opcode;
    logic [2:0] funct3;
    word_t      imm_i;
    word_t      imm_s;
    word_t      imm_shamt;
    logic       is_shift;

    assign opcode = inst.inst[6:0];
    assign funct3 = inst.inst[14:12];

    // Immediate forms
    assign imm_i     = {{20{inst.inst[31]}}, inst.inst[31:20]};
    assign imm_s     = {{20{inst.inst[31]}}, inst.inst[31:25], inst.inst[11:7]};
    assign imm_shamt = {{(XLEN-SHAMT_W){1'b0}}, inst.inst[20 +: SHAMT_W]};

    // slli, srli and srai
    assign is_shift = (funct3 == 3'b001) || (funct3 == 3'b101);

    always_comb begin
        ctrl     = '0;
        imm      = '0;
        rs1_addr = inst.inst[19:15];
        rs2_addr = inst.inst[24:20];
        rd_addr  = inst.inst[11:7];

        case (opcode)
            OPC_OP: begin
                ctrl.reg_write = 1'b1;
                ctrl.alu_op    = alu_op_e'({inst.inst[30], funct3});
            end
            OPC_OP_IMM: begin
                ctrl.reg_write = 1'b1;
                ctrl.alu_src   = 1'b1;
                rs2_addr       = '0;
                if (is_shift) begin
                    imm         = imm_shamt;
                    ctrl.alu_op = alu_op_e'({inst.inst[30], funct3});
                end else begin
                    // Bit 30 belongs to the immediate here
                    imm         = imm_i;
                    ctrl.alu_op = alu_op_e'({1'b0, funct3});
                end
            end
            OPC_LOAD: begin
                ctrl.reg_write = 1'b1;
                ctrl.mem_read  = 1'b1;
                ctrl.alu_src   = 1'b1;
                ctrl.alu_op    = ALU_ADD;
                rs2_addr       = '0;
                imm            = imm_i;
            end
            OPC_STORE: begin
                ctrl.mem_write = 1'b1;
                ctrl.alu_src   = 1'b1;
                ctrl.alu_op    = ALU_ADD;
                rd_addr        = '0;
                imm            = imm_s;
            end
            default: begin
                // Unknown opcode becomes a bubble
                rs1_addr = '0;
                rs2_addr = '0;
                rd_addr  = '0;
            end
        endcase
    end

endmodule

// File: design/rv_hazard_unit.sv
module rv_hazard_unit (
    input  rv_isa_pkg::reg_addr_t id_rs1_addr,
    input  rv_isa_pkg::reg_addr_t id_rs2_addr,
    input  rv_pipe_pkg::id_ex_t   id_ex,
    input  rv_pipe_pkg::ex_mem_t  ex_mem,
    input  rv_pipe_pkg::mem_wb_t  mem_wb,
    output rv_pipe_pkg::fwd_sel_e fwd_a,
    output rv_pipe_pkg::fwd_sel_e fwd_b,
    output logic                  load_use
);
    import rv_pipe_pkg::*;

    logic mem_src_ok;
    logic wb_src_ok;

    // Stages that will write a real register
    assign mem_src_ok = ex_mem.reg_write && (ex_mem.rd != '0);
    assign wb_src_ok  = mem_wb.reg_write && (mem_wb.rd != '0);

    // Younger result in EX/MEM wins over MEM/WB
    assign fwd_a = (mem_src_ok && (ex_mem.rd == id_ex.rs1_addr)) ? FWD_MEM :
                   (wb_src_ok  && (mem_wb.rd == id_ex.rs1_addr)) ? FWD_WB  : FWD_NONE;
    assign fwd_b = (mem_src_ok && (ex_mem.rd == id_ex.rs2_addr)) ? FWD_MEM :
                   (wb_src_ok  && (mem_wb.rd == id_ex.rs2_addr)) ? FWD_WB  : FWD_NONE;

    // Load in execute feeding the instruction in decode
    assign load_use = id_ex.ctrl.mem_read && (id_ex.rd != '0) &&
                      ((id_ex.rd == id_rs1_addr) || (id_ex.rd == id_rs2_addr));

endmodule

// File: design/rv_isa_pkg.sv
package rv_isa_pkg;

    localparam int XLEN     = 32;
    localparam int NUM_REGS = 32;
    localparam int SHAMT_W  = 5;

    typedef logic [XLEN-1:0]             word_t;
    typedef logic [$clog2(NUM_REGS)-1:0] reg_addr_t;
    typedef logic [6:0]                  opcode_t;

    // Major opcodes kept by this core
    localparam opcode_t OPC_OP     = 7'b0110011;
    localparam opcode_t OPC_OP_IMM = 7'b0010011;
    localparam opcode_t OPC_LOAD   = 7'b0000011;
    localparam opcode_t OPC_STORE  = 7'b0100011;

    // Encoded as {inst[30], funct3}
    typedef enum logic [3:0] {
        ALU_ADD = 4'b0000,
        ALU_SLL = 4'b0001,
        ALU_SLT = 4'b0010,
        ALU_XOR = 4'b0100,
        ALU_SRL = 4'b0101,
        ALU_OR  = 4'b0110,
        ALU_AND = 4'b0111,
        ALU_SUB = 4'b1000,
        ALU_SRA = 4'b1101
    } alu_op_e;

endpackage

// File: design/rv_pipe_pkg.sv
package rv_pipe_pkg;

    typedef struct packed {
        logic                reg_write;
        logic                mem_read;
        logic                mem_write;
        // Second operand comes from the immediate
        logic                alu_src;
        rv_isa_pkg::alu_op_e alu_op;
    } ctrl_t;

    typedef struct packed {
        rv_isa_pkg::word_t inst;
    } if_id_t;

    typedef struct packed {
        ctrl_t                 ctrl;
        rv_isa_pkg::word_t     rs1_val;
        rv_isa_pkg::word_t     rs2_val;
        rv_isa_pkg::word_t     imm;
        rv_isa_pkg::reg_addr_t rs1_addr;
        rv_isa_pkg::reg_addr_t rs2_addr;
        rv_isa_pkg::reg_addr_t rd;
    } id_ex_t;

    typedef struct packed {
        logic                  reg_write;
        logic                  mem_read;
        logic                  mem_write;
        rv_isa_pkg::word_t     alu_result;
        rv_isa_pkg::word_t     store_data;
        rv_isa_pkg::reg_addr_t rd;
    } ex_mem_t;

    typedef struct packed {
        logic                  reg_write;
        logic                  mem_read;
        rv_isa_pkg::word_t     alu_result;
        rv_isa_pkg::word_t     load_data;
        rv_isa_pkg::reg_addr_t rd;
    } mem_wb_t;

    typedef enum logic [1:0] {
        FWD_NONE,
        FWD_MEM,
        FWD_WB
    } fwd_sel_e;

    // addi x0, x0, 0
    localparam rv_isa_pkg::word_t NOP_INST = {25'd0, rv_isa_pkg::OPC_OP_IMM};
    localparam rv_isa_pkg::word_t RESET_PC = '0;

    // Value written back to the register file
    function automatic rv_isa_pkg::word_t wb_value(input mem_wb_t wb);
        return wb.mem_read ? wb.load_data : wb.alu_result;
    endfunction

endpackage

// File: design/rv_pipeline.sv
module rv_pipeline (
    input  logic              clk,
    input  logic              RST_n,
    output logic [29:0]       icache_addr,
    input  rv_isa_pkg::word_t icache_rdata,
    input  logic              icache_stall,
    output logic              dcache_ren,
    output logic              dcache_wen,
    output logic [29:0]       dcache_addr,
    output rv_isa_pkg::word_t dcache_wdata,
    input  rv_isa_pkg::word_t dcache_rdata,
    input  logic              dcache_stall,
    output rv_isa_pkg::word_t pc
);
    import rv_isa_pkg::*;
    import rv_pipe_pkg::*;

    // Cache buses carry words with the byte lanes reversed
    function automatic word_t swap_bytes(input word_t w);
        return {w[7:0], w[15:8], w[23:16], w[31:24]};
    endfunction

    function automatic word_t fwd_mux(input fwd_sel_e sel, input word_t stage_val,
                                      input word_t mem_val, input word_t wb_val);
        case (sel)
            FWD_MEM: return mem_val;
            FWD_WB:  return wb_val;
            default: return stage_val;
        endcase
    endfunction

    if_id_t    if_id_q;
    id_ex_t    id_ex_d;
    id_ex_t    id_ex_q;
    ex_mem_t   ex_mem_d;
    ex_mem_t   ex_mem_q;
    mem_wb_t   mem_wb_d;
    mem_wb_t   mem_wb_q;

    logic      freeze;
    logic      load_use;
    ctrl_t     dec_ctrl;
    reg_addr_t dec_rs1;
    reg_addr_t dec_rs2;
    reg_addr_t dec_rd;
    word_t     dec_imm;
    word_t     rf_rs1;
    word_t     rf_rs2;
    fwd_sel_e  fwd_a;
    fwd_sel_e  fwd_b;
    word_t     wb_val;
    word_t     op_a;
    word_t     op_b;
    word_t     alu_b;
    word_t     alu_result;

    // Any cache stall freezes the whole pipe
    assign freeze = icache_stall | dcache_stall;

    // Fetch
    assign icache_addr = pc[31:2];

    always_ff @(posedge clk) begin
        if (!RST_n) begin
            pc           <= RESET_PC;
            if_id_q.inst <= NOP_INST;
        end else if (!freeze && !load_use) begin
            pc           <= pc + 32'd4;
            if_id_q.inst <= swap_bytes(icache_rdata);
        end
    end

    // Decode
    rv_decoder u_decoder (
        .inst     (if_id_q),
        .ctrl     (dec_ctrl),
        .rs1_addr (dec_rs1),
        .rs2_addr (dec_rs2),
        .rd_addr  (dec_rd),
        .imm      (dec_imm)
    );

    rv_regfile u_regfile (
        .clk      (clk),
        .RST_n    (RST_n),
        .rs1_addr (dec_rs1),
        .rs2_addr (dec_rs2),
        .rs1_data (rf_rs1),
        .rs2_data (rf_rs2),
        .wb       (mem_wb_q)
    );

    always_comb begin
        // Load-use sends a bubble into execute
        id_ex_d.ctrl     = load_use ? ctrl_t'('0) : dec_ctrl;
        id_ex_d.rs1_val  = rf_rs1;
        id_ex_d.rs2_val  = rf_rs2;
        id_ex_d.imm      = dec_imm;
        id_ex_d.rs1_addr = dec_rs1;
        id_ex_d.rs2_addr = dec_rs2;
        id_ex_d.rd       = dec_rd;
    end

    always_ff @(posedge clk) begin
        if (!RST_n) begin
            id_ex_q.ctrl <= '0;
        end else if (!freeze) begin
            id_ex_q <= id_ex_d;
        end
    end

    // Execute
    rv_hazard_unit u_hazard (
        .id_rs1_addr (dec_rs1),
        .id_rs2_addr (dec_rs2),
        .id_ex       (id_ex_q),
        .ex_mem      (ex_mem_q),
        .mem_wb      (mem_wb_q),
        .fwd_a       (fwd_a),
        .fwd_b       (fwd_b),
        .load_use    (load_use)
    );

    assign wb_val = wb_value(mem_wb_q);
    assign op_a   = fwd_mux(fwd_a, id_ex_q.rs1_val, ex_mem_q.alu_result, wb_val);
    assign op_b   = fwd_mux(fwd_b, id_ex_q.rs2_val, ex_mem_q.alu_result, wb_val);
    assign alu_b  = id_ex_q.ctrl.alu_src ? id_ex_q.imm : op_b;

    rv_alu u_alu (
        .op     (id_ex_q.ctrl.alu_op),
        .a      (op_a),
        .b      (alu_b),
        .result (alu_result)
    );

    always_comb begin
        ex_mem_d.reg_write  = id_ex_q.ctrl.reg_write;
        ex_mem_d.mem_read   = id_ex_q.ctrl.mem_read;
        ex_mem_d.mem_write  = id_ex_q.ctrl.mem_write;
        ex_mem_d.alu_result = alu_result;
        // Forwarded rs2 is the store data
        ex_mem_d.store_data = op_b;
        ex_mem_d.rd         = id_ex_q.rd;
    end

    always_ff @(posedge clk) begin
        if (!RST_n) begin
            ex_mem_q.reg_write <= 1'b0;
            ex_mem_q.mem_read  <= 1'b0;
            ex_mem_q.mem_write <= 1'b0;
        end else if (!freeze) begin
            ex_mem_q <= ex_mem_d;
        end
    end

    // Memory
    assign dcache_ren   = ex_mem_q.mem_read;
    assign dcache_wen   = ex_mem_q.mem_write;
    assign dcache_addr  = ex_mem_q.alu_result[31:2];
    assign dcache_wdata = swap_bytes(ex_mem_q.store_data);

    always_comb begin
        mem_wb_d.reg_write  = ex_mem_q.reg_write;
        mem_wb_d.mem_read   = ex_mem_q.mem_read;
        mem_wb_d.alu_result = ex_mem_q.alu_result;
        mem_wb_d.load_data  = swap_bytes(dcache_rdata);
        mem_wb_d.rd         = ex_mem_q.rd;
    end

    always_ff @(posedge clk) begin
        if (!RST_n) begin
            mem_wb_q.reg_write <= 1'b0;
            mem_wb_q.mem_read  <= 1'b0;
        end else if (!freeze) begin
            mem_wb_q <= mem_wb_d;
        end
    end

endmodule

// File: design/rv_regfile.sv
module rv_regfile (
    input  logic                  clk,
    input  logic                  RST_n,
    input  rv_isa_pkg::reg_addr_t rs1_addr,
    input  rv_isa_pkg::reg_addr_t rs2_addr,
    output rv_isa_pkg::word_t     rs1_data,
    output rv_isa_pkg::word_t     rs2_data,
    input  rv_pipe_pkg::mem_wb_t  wb
);
    import rv_isa_pkg::*;
    import rv_pipe_pkg::*;

    word_t regs [NUM_REGS];
    word_t wb_data;
    logic  wb_en;

    assign wb_data = wb_value(wb);
    // x0 stays zero
    assign wb_en   = wb.reg_write && (wb.rd != '0);

    always_ff @(posedge clk) begin
        if (!RST_n) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_en) begin
            regs[wb.rd] <= wb_data;
        end
    end

    // Same-cycle write passes straight through to decode
    assign rs1_data = (wb_en && (wb.rd == rs1_addr)) ? wb_data : regs[rs1_addr];
    assign rs2_data = (wb_en && (wb.rd == rs2_addr)) ? wb_data : regs[rs2_addr];

endmodule

// File: rv_pipeline.f
design/rv_isa_pkg.sv
design/rv_pipe_pkg.sv
design/rv_alu.sv
design/rv_decoder.sv
design/rv_regfile.sv
design/rv_hazard_unit.sv
design/rv_pipeline.sv
testbench/tb_rv_pipeline.sv

// File: testbench/tb_rv_pipeline.sv
module tb_rv_pipeline;
    import rv_isa_pkg::*;
    import rv_pipe_pkg::*;

    localparam int CLK_PERIOD     = 100;
    localparam int DRIVE_DLY      = 10;
    localparam int RESET_CYCLES   = 10;
    localparam int PROG_LEN       = 200;
    localparam int DMEM_WORDS     = 64;
    localparam int TIMEOUT_CYCLES = 10 * (PROG_LEN + 20);
    localparam int DRAIN_PC       = (PROG_LEN + 6) * 4;

    logic        clk;
    logic        RST_n;
    logic [29:0] icache_addr;
    word_t       icache_rdata;
    logic        icache_stall;
    logic        dcache_ren;
    logic        dcache_wen;
    logic [29:0] dcache_addr;
    word_t       dcache_wdata;
    word_t       dcache_rdata;
    logic        dcache_stall;
    word_t       pc;

    integer seed = 84883;
    word_t  prog [PROG_LEN];
    word_t  dmem [DMEM_WORDS];
    word_t  exp_addr [$];
    word_t  exp_data [$];
    word_t  exp_load [$];
    int     expected_total;
    int     stores_seen = 0;
    int     cycles = 0;
    int     reset_count = 0;
    word_t  exp_pc;
    word_t  prev_pc = '0;
    logic   prev_hold = 1'b0;
    logic   bubble_in_ex = 1'b0;
    logic   hazard_now;
    logic   started = 1'b0;

    rv_pipeline u_dut (
        .clk          (clk),
        .RST_n        (RST_n),
        .icache_addr  (icache_addr),
        .icache_rdata (icache_rdata),
        .icache_stall (icache_stall),
        .dcache_ren   (dcache_ren),
        .dcache_wen   (dcache_wen),
        .dcache_addr  (dcache_addr),
        .dcache_wdata (dcache_wdata),
        .dcache_rdata (dcache_rdata),
        .dcache_stall (dcache_stall),
        .pc           (pc)
    );

    function automatic word_t reverse_bytes(input word_t w);
        return {w[7:0], w[15:8], w[23:16], w[31:24]};
    endfunction

    function automatic word_t fetch_word(input int idx);
        if (idx < 0 || idx >= PROG_LEN) begin
            return NOP_INST;
        end
        return prog[idx];
    endfunction

    function automatic word_t init_word(input int idx);
        return (32'h9E37_79B9 * (idx + 1)) ^ idx;
    endfunction

    function automatic reg_addr_t rand_reg();
        return reg_addr_t'($random(seed) & 7);
    endfunction

    function automatic logic [11:0] rand_offset();
        return 12'(($random(seed) & (DMEM_WORDS - 1)) << 2);
    endfunction

    // Cache models with combinational reads and byte-reversed lanes
    assign icache_rdata = reverse_bytes((icache_addr < PROG_LEN) ? prog[icache_addr] : NOP_INST);
    assign dcache_rdata = reverse_bytes(dmem[dcache_addr[5:0]]);

    initial begin
        clk = 1'b0;
    end

    always #(CLK_PERIOD / 2) clk = ~clk;

    // Reset and random stalls driven just after the rising edge
    always @(posedge clk) begin
        #DRIVE_DLY;
        if (reset_count < RESET_CYCLES) begin
            reset_count++;
        end
        RST_n        = (reset_count >= RESET_CYCLES);
        icache_stall = RST_n && (($random(seed) & 3) == 0);
        dcache_stall = RST_n && (($random(seed) & 3) == 0);
    end

    task automatic abort_run();
        $display("Finished with errors");
        $fatal(1);
    endtask

    task automatic check_word(input string name, input word_t actual, input word_t expected);
        assert (actual === expected)
        else begin
            $display("error at %0t: %s is %h, expected %h", $time, name, actual, expected);
            abort_run();
        end
    endtask

    task automatic build_program();
        int          i;
        int          kind;
        int          sel;
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [11:0] off;
        reg_addr_t   rd;
        reg_addr_t   rs1;
        reg_addr_t   rs2;
        reg_addr_t   last_rd;
        i = 0;
        last_rd = '0;
        while (i < PROG_LEN) begin
            kind = ($random(seed) & 7);
            sel  = ($random(seed) & 15);
            rd   = rand_reg();
            rs1  = rand_reg();
            rs2  = rand_reg();
            // Often chain on the previous result
            if ($random(seed) & 1) begin
                rs1 = last_rd;
            end
            case (kind)
                0, 1: begin
                    sel = sel % 6;
                    f3  = (sel == 0 || sel == 1) ? 3'd0 : (sel == 2) ? 3'd7 :
                          (sel == 3) ? 3'd6 : (sel == 4) ? 3'd4 : 3'd2;
                    f7  = (sel == 1) ? 7'h20 : 7'h00;
                    prog[i] = {f7, rs2, rs1, f3, rd, OPC_OP};
                    last_rd = rd;
                end
                2, 3: begin
                    sel = sel % 5;
                    f3  = (sel == 0) ? 3'd0 : (sel == 1) ? 3'd2 : (sel == 2) ? 3'd4 :
                          (sel == 3) ? 3'd6 : 3'd7;
                    prog[i] = {12'($random(seed)), rs1, f3, rd, OPC_OP_IMM};
                    last_rd = rd;
                end
                4: begin
                    sel = sel % 3;
                    f3  = (sel == 0) ? 3'd1 : 3'd5;
                    f7  = (sel == 2) ? 7'h20 : 7'h00;
                    prog[i] = {f7, 5'($random(seed)), rs1, f3, rd, OPC_OP_IMM};
                    last_rd = rd;
                end
                5: begin
                    off = rand_offset();
                    prog[i] = {off, 5'd0, 3'b010, rd, OPC_LOAD};
                    // Load-use partner right behind the load
                    if (i + 1 < PROG_LEN) begin
                        i++;
                        off = rand_offset();
                        if (sel & 1) begin
                            prog[i] = {off[11:5], rd, 5'd0, 3'b010, off[4:0], OPC_STORE};
                        end else begin
                            prog[i] = {7'h00, rand_reg(), rd, 3'b000, rand_reg(), OPC_OP};
                        end
                    end
                    last_rd = rd;
                end
                default: begin
                    off = rand_offset();
                    rs2 = (sel & 1) ? last_rd : rs2;
                    prog[i] = {off[11:5], rs2, 5'd0, 3'b010, off[4:0], OPC_STORE};
                end
            endcase
            i++;
        end
    endtask

    function automatic word_t alu_ref(input logic [2:0] f3, input logic alt,
                                      input word_t a, input word_t b);
        logic signed [31:0] sa;
        sa = a;
        case (f3)
            3'd0: return alt ? a - b : a + b;
            3'd1: return a << b[4:0];
            3'd2: return {31'd0, ($signed(a) < $signed(b))};
            3'd4: return a ^ b;
            3'd5: return alt ? word_t'(sa >>> b[4:0]) : a >> b[4:0];
            3'd6: return a | b;
            3'd7: return a & b;
            default: return '0;
        endcase
    endfunction

    // In-order instruction-set model of the whole program
    task automatic run_model();
        word_t      regs [NUM_REGS];
        word_t      mem [DMEM_WORDS];
        word_t      inst;
        word_t      imm_i;
        word_t      imm_s;
        word_t      addr;
        word_t      res;
        logic [2:0] f3;
        logic       writes;
        for (int r = 0; r < NUM_REGS; r++) begin
            regs[r] = '0;
        end
        for (int m = 0; m < DMEM_WORDS; m++) begin
            mem[m] = init_word(m);
        end
        for (int i = 0; i < PROG_LEN; i++) begin
            inst   = prog[i];
            f3     = inst[14:12];
            imm_i  = {{20{inst[31]}}, inst[31:20]};
            imm_s  = {{20{inst[31]}}, inst[31:25], inst[11:7]};
            writes = 1'b1;
            res    = '0;
            case (inst[6:0])
                OPC_OP: res = alu_ref(f3, inst[30], regs[inst[19:15]], regs[inst[24:20]]);
                OPC_OP_IMM: res = alu_ref(f3, (f3 == 3'd5) && inst[30], regs[inst[19:15]], imm_i);
                OPC_LOAD: begin
                    addr = regs[inst[19:15]] + imm_i;
                    res  = mem[addr[7:2]];
                    exp_load.push_back(addr);
                end
                OPC_STORE: begin
                    addr   = regs[inst[19:15]] + imm_s;
                    writes = 1'b0;
                    mem[addr[7:2]] = regs[inst[24:20]];
                    exp_addr.push_back(addr);
                    exp_data.push_back(regs[inst[24:20]]);
                end
                default: writes = 1'b0;
            endcase
            if (writes && inst[11:7] != 5'd0) begin
                regs[inst[11:7]] = res;
            end
        end
        expected_total = exp_addr.size();
    endtask

    // Load in execute whose rd feeds the instruction in decode
    function automatic logic load_use_expected(input word_t fetch_pc);
        word_t d;
        word_t e;
        logic  uses_rs2;
        d = fetch_word(int'(fetch_pc >> 2) - 1);
        e = fetch_word(int'(fetch_pc >> 2) - 2);
        uses_rs2 = (d[6:0] == OPC_OP) || (d[6:0] == OPC_STORE);
        return (e[6:0] == OPC_LOAD) && (e[11:7] != 5'd0) &&
               ((e[11:7] == d[19:15]) || (uses_rs2 && (e[11:7] == d[24:20])));
    endfunction

    // Checker and data cache writes on the falling edge
    always @(negedge clk) begin
        cycles++;
        if (cycles > TIMEOUT_CYCLES) begin
            $display("Timeout: the program did not drain within %0d cycles", TIMEOUT_CYCLES);
            abort_run();
        end
        if (!RST_n || !started) begin
            exp_pc = RESET_PC;
            check_word("dcache_ren", word_t'(dcache_ren), '0);
            check_word("dcache_wen", word_t'(dcache_wen), '0);
        end else begin
            exp_pc = prev_hold ? prev_pc : prev_pc + 32'd4;
        end
        check_word("pc", pc, exp_pc);
        check_word("icache_addr", word_t'(icache_addr), exp_pc >> 2);
        if (RST_n && dcache_ren && !dcache_stall && !icache_stall) begin
            assert (exp_load.size() > 0)
            else begin
                $display("A load was issued after all expected loads were seen");
                abort_run();
            end
            check_word("dcache_addr", word_t'(dcache_addr), exp_load[0] >> 2);
            void'(exp_load.pop_front());
        end
        if (RST_n && dcache_wen && !dcache_stall && !icache_stall) begin
            assert (exp_addr.size() > 0)
            else begin
                $display("A store was accepted after all expected stores were seen");
                abort_run();
            end
            check_word("dcache_addr", word_t'(dcache_addr), exp_addr[0] >> 2);
            check_word("dcache_wdata (unreversed)", reverse_bytes(dcache_wdata), exp_data[0]);
            dmem[dcache_addr[5:0]] = reverse_bytes(dcache_wdata);
            void'(exp_addr.pop_front());
            void'(exp_data.pop_front());
            stores_seen++;
        end
        hazard_now = load_use_expected(exp_pc) && !bubble_in_ex;
        prev_hold  = icache_stall || dcache_stall || hazard_now;
        if (!(icache_stall || dcache_stall)) begin
            bubble_in_ex = hazard_now;
        end
        prev_pc = exp_pc;
        started = RST_n;
    end

    initial begin
        RST_n        = 1'b0;
        icache_stall = 1'b0;
        dcache_stall = 1'b0;
        for (int m = 0; m < DMEM_WORDS; m++) begin
            dmem[m] = init_word(m);
        end
        build_program();
        run_model();
        wait (RST_n);
        @(negedge clk);
        while (pc < DRAIN_PC) begin
            @(negedge clk);
        end
        @(posedge clk);
        check_word("unissued load count", word_t'(exp_load.size()), '0);
        check_word("accepted store count", word_t'(stores_seen), word_t'(expected_total));
        $display("Finished with no errors");
        $finish;
    end

endmodule
